//--- vlog.f
source/ide_pkg.sv
source/ide_req_if.sv
source/ide_apb_decode.sv
source/ide_pio.sv
source/ide_read_result.sv
source/ide_ctrl_top.sv
tb/ide_disk_model.sv
tb/tb_ide_ctrl.sv

//--- tb/tb_ide_ctrl.sv
`timescale 1ns/1ps

module tb_ide_ctrl
	import ide_pkg::*;
();

	// all six tests take well under a thousand cycles
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int POLL_LIMIT = 100;

	logic      clk;
	logic      reset;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	ide_word_t pwdata;
	ide_word_t prdata;
	logic      pready;
	logic      pslverr;
	wire [15:0] ide_d;
	ide_reg_t  ide_a;
	logic      ide_dir;
	logic      ide_cs0_n;
	logic      ide_cs1_n;
	logic      ide_rd_n;
	logic      ide_wr_n;

	logic      strobe_low;
	logic      cs_low;
	logic [31:0] lfsr_state;
	ide_word_t exp_regs [8];
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err_base = 0;
	int cycle_count = 0;
	int strobe_count = 0;

	ide_ctrl_top u_ide_ctrl_top (
		.clk       (clk),
		.reset     (reset),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.ide_d     (ide_d),
		.ide_a     (ide_a),
		.ide_dir   (ide_dir),
		.ide_cs0_n (ide_cs0_n),
		.ide_cs1_n (ide_cs1_n),
		.ide_rd_n  (ide_rd_n),
		.ide_wr_n  (ide_wr_n)
	);

	ide_disk_model u_disk (
		.ide_d     (ide_d),
		.ide_a     (ide_a),
		.ide_dir   (ide_dir),
		.ide_cs0_n (ide_cs0_n),
		.ide_cs1_n (ide_cs1_n),
		.ide_rd_n  (ide_rd_n),
		.ide_wr_n  (ide_wr_n)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	assign strobe_low = !ide_rd_n || !ide_wr_n;
	assign cs_low = !ide_cs0_n || !ide_cs1_n;

	// every read strobe, block or host
	always @(negedge ide_rd_n)
		strobe_count++;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// strobe low for two cycles
	assert property (@(posedge clk) disable iff (reset)
		$rose(strobe_low) |-> ##1 strobe_low ##1 !strobe_low)
		else
		begin
			$display("FAILED %0t ns: strobe width not 2 cycles", $time);
			errors++;
		end

	// chip select one cycle either side of the strobe
	assert property (@(posedge clk) disable iff (reset)
		$rose(strobe_low) |-> ($past(cs_low) && cs_low) ##1 cs_low ##1 cs_low ##1 !cs_low)
		else
		begin
			$display("FAILED %0t ns: chip select not framing the strobe", $time);
			errors++;
		end

	// host side released while the drive drives a read
	assert property (@(posedge clk) disable iff (reset) !ide_rd_n |-> ide_dir)
		else
		begin
			$display("FAILED %0t ns: read strobe with host driving the bus", $time);
			errors++;
		end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_word(output ide_word_t w);
		w = '0;
		for (int i = 0; i < 16; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[14:0], lfsr_state[0]};
		end
	endtask

	function automatic apb_addr_t cs0_addr(input int r);
		return ADDR_CS0_BASE + apb_addr_t'(r * 4);
	endfunction

	// one apb transfer, cycles counts the access phase
	task automatic apb_access(input logic write, input apb_addr_t addr, input ide_word_t wdata,
		output ide_word_t rdata, output logic err, output int cycles);
		logic done;
		@(posedge clk);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#2;
		penable = 1'b1;
		cycles = 0;
		done = 1'b0;
		while (!done)
		begin
			// mid-cycle, away from the edges
			@(negedge clk);
			cycles++;
			if (pready)
			begin
				done = 1'b1;
				rdata = prdata;
				err = pslverr;
			end
		end
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic reg_write(input apb_addr_t addr, input ide_word_t data, output int cycles);
		ide_word_t unused;
		logic err;
		apb_access(1'b1, addr, data, unused, err, cycles);
	endtask

	task automatic reg_read(input apb_addr_t addr, output ide_word_t data, output logic err,
		output int cycles);
		apb_access(1'b0, addr, '0, data, err, cycles);
	endtask

	task automatic check_word(input string what, input ide_word_t got, input ide_word_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("FAILED %0t ns: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("FAILED %0t ns: %s got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// poll status until the fifo holds at least want words
	task automatic wait_fifo_level(input int want);
		ide_word_t stat;
		logic err;
		int cyc;
		int polls;
		stat = '0;
		polls = 0;
		while ((int'(stat[STAT_LVL_LSB +: 4]) < want) && (polls < POLL_LIMIT))
		begin
			reg_read(ADDR_STATUS, stat, err, cyc);
			polls++;
		end
		if (int'(stat[STAT_LVL_LSB +: 4]) < want)
		begin
			$display("fifo never reached level %0d by %0t ns", want, $time);
			errors++;
		end
	endtask

	task automatic wait_block_idle();
		ide_word_t stat;
		logic err;
		int cyc;
		int polls;
		stat = 16'h0001;
		polls = 0;
		while (stat[STAT_BUSY_BIT] && (polls < POLL_LIMIT))
		begin
			reg_read(ADDR_STATUS, stat, err, cyc);
			polls++;
		end
		if (stat[STAT_BUSY_BIT])
		begin
			$display("block still busy at %0t ns", $time);
			errors++;
		end
	endtask

	task automatic pop_expect(input ide_word_t exp, input int idx);
		ide_word_t rd;
		logic err;
		int cyc;
		wait_fifo_level(1);
		reg_read(ADDR_FIFO, rd, err, cyc);
		check_word($sformatf("fifo word %0d", idx), rd, exp);
		check_bit("pslverr on pop", err, 1'b0);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_err_base)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - test_err_base);
		end
		test_err_base = errors;
	endtask

	initial
	begin
		ide_word_t v;
		ide_word_t rd;
		ide_word_t stat;
		logic err;
		int cyc;
		int snap;

		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lfsr_state = 32'h53335b33;
		repeat (2)
			@(posedge clk);
		#2;
		reset = 1'b0;

		// idle pins straight out of reset
		@(negedge clk);
		check_bit("cs0_n after reset", ide_cs0_n, 1'b1);
		check_bit("cs1_n after reset", ide_cs1_n, 1'b1);
		check_bit("rd_n after reset", ide_rd_n, 1'b1);
		check_bit("wr_n after reset", ide_wr_n, 1'b1);
		check_bit("dir after reset", ide_dir, 1'b1);
		check_bit("pready after reset", pready, 1'b0);
		finish_test("reset state");

		// task register write and readback
		for (int r = 1; r < 8; r++)
		begin
			draw_word(v);
			exp_regs[r] = v;
			reg_write(cs0_addr(r), v, cyc);
		end
		for (int r = 1; r < 8; r++)
		begin
			reg_read(cs0_addr(r), rd, err, cyc);
			check_word($sformatf("cs0 reg %0d readback", r), rd, exp_regs[r]);
		end
		reg_read(ADDR_CS1_BASE + 8'h18, rd, err, cyc);
		check_word("cs1 reg 6", rd, 16'h0050);
		finish_test("task registers");

		// access phase length on an idle engine
		draw_word(v);
		exp_regs[5] = v;
		reg_write(cs0_addr(5), v, cyc);
		check_word("write access cycles", ide_word_t'(cyc), 16'd6);
		reg_read(cs0_addr(5), rd, err, cyc);
		check_word("read access cycles", ide_word_t'(cyc), 16'd6);
		check_word("cs0 reg 5 rewrite", rd, v);
		reg_read(ADDR_CS1_BASE + 8'h18, rd, err, cyc);
		check_word("cs1 read access cycles", ide_word_t'(cyc), 16'd6);
		reg_write(ADDR_CS1_BASE + 8'h08, 16'h0000, cyc);
		check_word("cs1 write access cycles", ide_word_t'(cyc), 16'd6);
		finish_test("pio timing");

		// short block, fits in the fifo
		draw_word(v);
		reg_write(cs0_addr(0), v, cyc);
		reg_write(ADDR_BLK_CNT, 16'd8, cyc);
		wait_block_idle();
		for (int i = 0; i < 8; i++)
			pop_expect(v + ide_word_t'(i), i);
		reg_read(ADDR_BLK_CNT, rd, err, cyc);
		check_word("block count after block", rd, 16'd0);
		finish_test("short block");

		// 12 words against an 8 deep fifo
		draw_word(v);
		reg_write(cs0_addr(0), v, cyc);
		reg_write(ADDR_BLK_CNT, 16'd12, cyc);
		wait_fifo_level(FIFO_DEPTH);
		snap = strobe_count;
		repeat (30)
			@(posedge clk);
		reg_read(ADDR_STATUS, stat, err, cyc);
		check_word("stalled fifo level", ide_word_t'(stat[STAT_LVL_LSB +: 4]), 16'd8);
		check_bit("busy while stalled", stat[STAT_BUSY_BIT], 1'b1);
		check_bit("overflow attempt flag", stat[STAT_OVF_BIT], 1'b1);
		check_word("strobes while full", ide_word_t'(strobe_count - snap), 16'd0);
		for (int i = 0; i < 12; i++)
			pop_expect(v + ide_word_t'(i), i);
		// sticky flag cleared by a status write
		reg_write(ADDR_STATUS, 16'h0000, cyc);
		reg_read(ADDR_STATUS, stat, err, cyc);
		check_word("status after drain", stat, 16'h0000);
		finish_test("fifo back-pressure");

		// empty pop, then a host read racing a block
		reg_read(ADDR_FIFO, rd, err, cyc);
		check_word("empty pop data", rd, 16'h0000);
		check_bit("empty pop pslverr", err, 1'b1);
		draw_word(v);
		reg_write(cs0_addr(0), v, cyc);
		reg_write(ADDR_BLK_CNT, 16'd6, cyc);
		reg_read(cs0_addr(3), rd, err, cyc);
		check_word("task read during block", rd, exp_regs[3]);
		check_bit("task read pslverr", err, 1'b0);
		check_bit("task read waited for block", cyc > 6, 1'b1);
		wait_block_idle();
		for (int i = 0; i < 6; i++)
			pop_expect(v + ide_word_t'(i), i);
		finish_test("empty pop and host during block");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- tb/ide_disk_model.sv
`timescale 1ns/1ps

module ide_disk_model
	import ide_pkg::*;
(
	inout  wire [15:0] ide_d,
	input  ide_reg_t   ide_a,
	input  logic       ide_dir,
	input  logic       ide_cs0_n,
	input  logic       ide_cs1_n,
	input  logic       ide_rd_n,
	input  logic       ide_wr_n
);

	// cs0 task registers, slot 0 unused
	ide_word_t task_regs [8];

	// data register counter
	ide_word_t data_cnt;
	ide_word_t rd_word;
	logic      drive;

	initial
	begin
		data_cnt = '0;
		for (int i = 0; i < 8; i++)
			task_regs[i] = '0;
	end

	// word the drive would put on the bus
	always_comb
	begin
		rd_word = '0;
		if (ide_cs0_n === 1'b0)
		begin
			if (ide_a == 3'd0)
				rd_word = data_cnt;
			else
				rd_word = task_regs[ide_a];
		end
		// alternate status, drive ready and seek complete
		else if ((ide_cs1_n === 1'b0) && (ide_a == 3'd6))
			rd_word = 16'h0050;
	end

	// only while selected, reading, and the host has released the bus
	assign drive = ((ide_cs0_n === 1'b0) || (ide_cs1_n === 1'b0)) &&
		(ide_rd_n === 1'b0) && (ide_dir === 1'b1);
	assign ide_d = drive ? rd_word : 16'hzzzz;

	// post-increment once the host has taken the word
	always @(posedge ide_rd_n)
		if ((ide_cs0_n === 1'b0) && (ide_a == 3'd0))
			data_cnt <= data_cnt + 1'b1;

	// write data still on the bus at the rising strobe
	always @(posedge ide_wr_n)
		if (ide_cs0_n === 1'b0)
		begin
			if (ide_a == 3'd0)
				data_cnt <= ide_d;
			else
				task_regs[ide_a] <= ide_d;
		end

	// cs1 writes land nowhere

endmodule

//--- source/ide_ctrl_top.sv
`timescale 1ns/1ps

module ide_ctrl_top
	import ide_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	// apb slave
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  ide_word_t pwdata,
	output ide_word_t prdata,
	output logic      pready,
	output logic      pslverr,
	// ide connector
	inout  wire ide_word_t ide_d,
	output ide_reg_t  ide_a,
	output logic      ide_dir,
	output logic      ide_cs0_n,
	output logic      ide_cs1_n,
	output logic      ide_rd_n,
	output logic      ide_wr_n
);

	// fifo status and pop path between result and decode
	logic      fifo_full;
	logic      fifo_empty;
	fifo_lvl_t fifo_level;
	logic      pop;
	ide_word_t pop_data;

	// requests in, results out
	ide_req_if req_bus ();

	// apb side, host cycles and block sequencing
	ide_apb_decode u_decode (
		.clk        (clk),
		.reset      (reset),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.fifo_full  (fifo_full),
		.fifo_empty (fifo_empty),
		.fifo_level (fifo_level),
		.pop_data   (pop_data),
		.pop        (pop),
		.bus        (req_bus.decode)
	);

	// pin timing
	ide_pio u_pio (
		.clk       (clk),
		.reset     (reset),
		.bus       (req_bus.pio),
		.ide_d     (ide_d),
		.ide_a     (ide_a),
		.ide_dir   (ide_dir),
		.ide_cs0_n (ide_cs0_n),
		.ide_cs1_n (ide_cs1_n),
		.ide_rd_n  (ide_rd_n),
		.ide_wr_n  (ide_wr_n)
	);

	// block fifo
	ide_read_result u_result (
		.clk        (clk),
		.reset      (reset),
		.pop        (pop),
		.bus        (req_bus.result),
		.pop_data   (pop_data),
		.fifo_full  (fifo_full),
		.fifo_empty (fifo_empty),
		.fifo_level (fifo_level)
	);

endmodule

//--- source/ide_read_result.sv
`timescale 1ns/1ps

module ide_read_result
	import ide_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      pop,
	ide_req_if.result bus,
	output ide_word_t pop_data,
	output logic      fifo_full,
	output logic      fifo_empty,
	output fifo_lvl_t fifo_level
);

	// block words wait here for the host
	ide_word_t mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic push;
	logic do_push;
	logic do_pop;

	// host reads skip the fifo, decode takes rdata itself
	assign push = bus.rdy_stb && bus.rdata_blk;

	// guards kept so a stray request cannot corrupt the pointers
	assign do_push = push && !fifo_full;
	assign do_pop = pop && !fifo_empty;

	assign fifo_full = (fifo_level == fifo_lvl_t'(FIFO_DEPTH));
	assign fifo_empty = (fifo_level == '0);

	// show-ahead, head word valid while not empty
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk)
		if (do_push)
			mem[wr_ptr] <= bus.rdata;

	// depth is a power of two, pointers wrap on their own
	always_ff @(posedge clk)
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end

	always_ff @(posedge clk)
		if (reset)
			fifo_level <= '0;
		else
		begin
			case ({do_push, do_pop})
				2'b10:
					fifo_level <= fifo_level + 1'b1;
				2'b01:
					fifo_level <= fifo_level - 1'b1;
				default:
					fifo_level <= fifo_level;
			endcase
		end

	// decode back-pressure must keep a full fifo from seeing a block word
	assert property (@(posedge clk) disable iff (reset) push |-> !fifo_full)
		else $error("block word pushed into a full fifo");

	assert property (@(posedge clk) disable iff (reset) pop |-> !fifo_empty)
		else $error("pop from an empty fifo");

endmodule

//--- source/ide_pio.sv
`timescale 1ns/1ps

module ide_pio
	import ide_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	ide_req_if.pio    bus,
	inout  wire ide_word_t ide_d,
	output ide_reg_t  ide_a,
	output logic      ide_dir,
	output logic      ide_cs0_n,
	output logic      ide_cs1_n,
	output logic      ide_rd_n,
	output logic      ide_wr_n
);

	// pio4 cycle at 25 MHz
	// go    cs, dir and address registered
	// st0   strobe asserted at its end
	// st1   strobe low
	// st2   strobe low, released and data sampled at its end
	// st3   cs and dir released at its end
	// st4   rdy_stb, engine free on the next cycle
	logic [PIO_STAGES-1:0] st;
	logic      go;
	logic      nxt_rnw;
	logic      nxt_cs1;
	ide_reg_t  nxt_reg;
	logic      cyc_rnw;
	logic      cyc_blk;
	ide_word_t wdata_q;
	ide_word_t rdata_q;

	assign bus.rdy = ~|st;
	assign bus.rdy_stb = st[PIO_STAGES-1];
	assign go = (bus.blk_req || bus.host_req) && bus.rdy;

	// block wins, always a read of cs0 reg 0
	assign nxt_rnw = bus.blk_req ? 1'b1 : bus.host_rnw;
	assign nxt_cs1 = bus.blk_req ? 1'b0 : bus.host_cs1;
	assign nxt_reg = bus.blk_req ? '0 : bus.host_reg;

	// one bit marches through the stages
	always_ff @(posedge clk)
		if (reset)
			st <= '0;
		else
			st <= {st[PIO_STAGES-2:0], go};

	always_ff @(posedge clk)
		if (reset)
		begin
			ide_dir <= 1'b1;
			ide_cs0_n <= 1'b1;
			ide_cs1_n <= 1'b1;
			ide_rd_n <= 1'b1;
			ide_wr_n <= 1'b1;
			ide_a <= '0;
			cyc_rnw <= 1'b1;
			cyc_blk <= 1'b0;
		end
		else if (go)
		begin
			// request latched here, decode may move on after rdy_stb
			ide_dir <= nxt_rnw;
			ide_cs0_n <= nxt_cs1;
			ide_cs1_n <= !nxt_cs1;
			ide_a <= nxt_reg;
			cyc_rnw <= nxt_rnw;
			cyc_blk <= bus.blk_req;
		end
		else if (st[0])
		begin
			ide_rd_n <= !cyc_rnw;
			ide_wr_n <= cyc_rnw;
		end
		else if (st[2])
		begin
			ide_rd_n <= 1'b1;
			ide_wr_n <= 1'b1;
		end
		else if (st[3])
		begin
			// bus back to the drive
			ide_dir <= 1'b1;
			ide_cs0_n <= 1'b1;
			ide_cs1_n <= 1'b1;
		end

	// write data for the whole cycle
	always_ff @(posedge clk)
		if (go)
			wdata_q <= bus.host_wdata;

	// drive data still valid at the rising edge of rd_n
	always_ff @(posedge clk)
		if (st[2] && cyc_rnw)
			rdata_q <= ide_d;

	// driven only while dir says write
	assign ide_d = ide_dir ? 'z : wdata_q;

	assign bus.rdata = rdata_q;
	assign bus.rdata_blk = cyc_blk;

	assert property (@(posedge clk) disable iff (reset) !(!ide_rd_n && !ide_wr_n))
		else $error("rd_n and wr_n low together");

	// strobe only inside a selected cycle
	assert property (@(posedge clk) disable iff (reset)
		(!ide_rd_n || !ide_wr_n) |-> $onehot({!ide_cs0_n, !ide_cs1_n}))
		else $error("strobe without exactly one chip select");

	assert property (@(posedge clk) disable iff (reset) $onehot0(st))
		else $error("stage register not one-hot");

endmodule

//--- source/ide_apb_decode.sv
`timescale 1ns/1ps

module ide_apb_decode
	import ide_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  ide_word_t pwdata,
	output ide_word_t prdata,
	output logic      pready,
	output logic      pslverr,
	input  logic      fifo_full,
	input  logic      fifo_empty,
	input  fifo_lvl_t fifo_level,
	input  ide_word_t pop_data,
	output logic      pop,
	ide_req_if.decode bus
);

	apb_state_t state;
	blk_cnt_t   blk_cnt;
	logic       blk_inflight;
	logic       ovf_sticky;
	logic       setup;
	logic       is_cs0;
	logic       is_cs1;
	logic       acc_cnt;
	logic       acc_fifo;
	logic       acc_stat;
	logic       blk_go;
	logic       blk_done;
	logic       host_done;
	logic       busy;
	fifo_lvl_t  fifo_used;
	ide_word_t  status_word;

	// apb setup phase, address and data already valid
	assign setup = psel && !penable;

	// task file windows, 8 words each
	assign is_cs0 = (paddr[7:5] == ADDR_CS0_BASE[7:5]);
	assign is_cs1 = (paddr[7:5] == ADDR_CS1_BASE[7:5]);
	assign acc_cnt = (paddr == ADDR_BLK_CNT);
	assign acc_fifo = (paddr == ADDR_FIFO);
	assign acc_stat = (paddr == ADDR_STATUS);

	// block gets the engine whenever it asks
	assign blk_go = bus.blk_req && bus.rdy;
	assign blk_done = bus.rdy_stb && bus.rdata_blk;

	// only one host cycle can be pending, so a non-block strobe is ours
	assign host_done = (state == HOST_WAIT) && bus.rdy_stb && !bus.rdata_blk;

	// words in the fifo plus the one on its way
	assign fifo_used = fifo_level + fifo_lvl_t'(blk_inflight);
	assign bus.blk_req = (blk_cnt != '0) && !fifo_full &&
		(fifo_used < fifo_lvl_t'(FIFO_DEPTH));
	assign busy = (blk_cnt != '0) || blk_inflight;

	always_ff @(posedge clk)
		if (reset)
		begin
			state <= IDLE;
			bus.host_req <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (setup)
					begin
						// task registers go out to the drive
						if (is_cs0 || is_cs1)
						begin
							state <= HOST_WAIT;
							bus.host_req <= 1'b1;
						end
						else
							state <= RESP;
					end
				HOST_WAIT:
					if (host_done)
					begin
						state <= IDLE;
						bus.host_req <= 1'b0;
					end
				default:
					state <= IDLE;
			endcase
		end

	// request fields captured in setup, stable until rdy_stb
	always_ff @(posedge clk)
		if ((state == IDLE) && setup && (is_cs0 || is_cs1))
		begin
			bus.host_rnw <= !pwrite;
			bus.host_reg <= paddr[4:2];
			bus.host_cs1 <= is_cs1;
			bus.host_wdata <= pwdata;
		end

	always_ff @(posedge clk)
		if (reset)
			blk_cnt <= '0;
		else if ((state == RESP) && pwrite && acc_cnt)
			blk_cnt <= (pwdata > ide_word_t'(BLK_CNT_MAX)) ? BLK_CNT_MAX : pwdata[8:0];
		else if (blk_go)
			blk_cnt <= blk_cnt - 1'b1;

	// set at block go, cleared when its word lands in the fifo
	always_ff @(posedge clk)
		if (reset)
			blk_inflight <= 1'b0;
		else if (blk_go)
			blk_inflight <= 1'b1;
		else if (blk_done)
			blk_inflight <= 1'b0;

	// block wanted more words while the fifo was full
	always_ff @(posedge clk)
		if (reset)
			ovf_sticky <= 1'b0;
		else if ((state == RESP) && pwrite && acc_stat)
			ovf_sticky <= 1'b0;
		else if ((blk_cnt != '0) && fifo_full)
			ovf_sticky <= 1'b1;

	always_comb
	begin
		status_word = '0;
		status_word[STAT_BUSY_BIT] = busy;
		status_word[STAT_LVL_LSB +: 4] = fifo_level;
		status_word[STAT_OVF_BIT] = ovf_sticky;
	end

	// local registers answer at once, task registers at their strobe
	assign pready = (state == RESP) || host_done;
	assign pop = (state == RESP) && !pwrite && acc_fifo && !fifo_empty;
	assign pslverr = (state == RESP) && !pwrite && acc_fifo && fifo_empty;

	always_comb
	begin
		prdata = '0;
		if (host_done && bus.host_rnw)
			prdata = bus.rdata;
		else if ((state == RESP) && !pwrite)
		begin
			if (acc_cnt)
				prdata = ide_word_t'(blk_cnt);
			else if (acc_fifo && !fifo_empty)
				prdata = pop_data;
			else if (acc_stat)
				prdata = status_word;
		end
	end

	// pready never ends anything but an access phase
	assert property (@(posedge clk) disable iff (reset) pready |-> (psel && penable))
		else $error("pready outside apb access phase");

	assert property (@(posedge clk) disable iff (reset) bus.host_req |-> (state == HOST_WAIT))
		else $error("host_req raised outside HOST_WAIT");

endmodule

//--- source/ide_req_if.sv
`timescale 1ns/1ps

interface ide_req_if
	import ide_pkg::*;
();

	// host register cycle, held by decode until its rdy_stb
	logic      host_req;
	logic      host_rnw;
	ide_reg_t  host_reg;
	logic      host_cs1;
	ide_word_t host_wdata;

	// block read of the data register, cs0 reg 0
	logic      blk_req;

	// engine handshake and read results
	logic      rdy;
	logic      rdy_stb;
	ide_word_t rdata;
	logic      rdata_blk;

	modport decode (
		output host_req, host_rnw, host_reg, host_cs1, host_wdata, blk_req,
		input  rdy, rdy_stb, rdata, rdata_blk
	);

	modport pio (
		input  host_req, host_rnw, host_reg, host_cs1, host_wdata, blk_req,
		output rdy, rdy_stb, rdata, rdata_blk
	);

	// fifo side only sees finished cycles
	modport result (
		input  rdy_stb, rdata, rdata_blk
	);

endinterface

//--- source/ide_pkg.sv
package ide_pkg;

	// one word on the drive data bus
	typedef logic [15:0] ide_word_t;

	// task file register index
	typedef logic [2:0] ide_reg_t;

	// apb byte address
	typedef logic [7:0] apb_addr_t;

	// words left in a block, 0 to 256
	typedef logic [8:0] blk_cnt_t;

	// fifo fill level, 0 to 8
	typedef logic [3:0] fifo_lvl_t;

	// block fifo entries
	localparam int FIFO_DEPTH = 8;

	// one-hot timing stages of a pio4 register cycle
	localparam int PIO_STAGES = 5;

	// largest block length accepted by a count write
	localparam blk_cnt_t BLK_CNT_MAX = 9'd256;

	// task registers 0..7 with cs0, one per 32-bit word
	localparam apb_addr_t ADDR_CS0_BASE = 8'h00;

	// task registers 0..7 with cs1
	localparam apb_addr_t ADDR_CS1_BASE = 8'h20;

	// write starts a block, read gives the words still to fetch
	localparam apb_addr_t ADDR_BLK_CNT = 8'h40;

	// read pops one block word
	localparam apb_addr_t ADDR_FIFO = 8'h44;

	// busy, fifo level, overflow attempt
	localparam apb_addr_t ADDR_STATUS = 8'h48;

	// status word layout
	localparam int STAT_BUSY_BIT = 0;
	localparam int STAT_LVL_LSB = 4;
	localparam int STAT_OVF_BIT = 8;

	// decode fsm
	// IDLE      waits for an apb setup phase
	// HOST_WAIT task register cycle queued or running on the drive
	// RESP      local register, answered in the first access cycle
	typedef enum logic [1:0]
	{
		IDLE,
		HOST_WAIT,
		RESP
	} apb_state_t;

endpackage
